//--- include/axi_fabric_settings.svh
`ifndef AXI_FABRIC_SETTINGS_SVH
`define AXI_FABRIC_SETTINGS_SVH

// request sources and memory banks
`define AXI_NUM_SI 4
`define AXI_NUM_MI 4

// the top two ID bits name the source, the rest is a free tag
`define AXI_ID_W       8
`define AXI_SRC_ID_LSB 6

`define AXI_ADDR_W 32
`define AXI_DATA_W 32

// bank select sits just above the 64-byte line offset
`define AXI_BANK_SEL_LSB 6

// storage per bank in words
`define AXI_BANK_WORDS 256

`endif

//--- source/axi_fabric_pkg.sv
`include "axi_fabric_settings.svh"

package axi_fabric_pkg;

   typedef logic [`AXI_ID_W-1:0]   axi_id_t;
   typedef logic [`AXI_ADDR_W-1:0] axi_addr_t;
   typedef logic [`AXI_DATA_W-1:0] axi_data_t;
   // beats minus one
   typedef logic [7:0]             axi_len_t;
   typedef logic [2:0]             axi_size_t;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      SLVERR = 2'b10
   } axi_resp_e;

   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } axi_aw_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      logic      last;
   } axi_w_t;

   typedef struct packed {
      axi_id_t   id;
      axi_resp_e resp;
   } axi_b_t;

   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
      axi_size_t size;
   } axi_ar_t;

   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_e resp;
      logic      last;
   } axi_r_t;

   typedef enum logic [1:0] {
      IDLE,
      WRITE,
      WRESP,
      READ
   } bank_state_e;

endpackage

//--- source/rr_sched.sv
`timescale 1ns/1ps

module rr_sched #(
   parameter int IN_WIDTH  = 4,
   parameter int OUT_WIDTH = 2
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [IN_WIDTH-1:0]  in,
   input  logic                 advance,
   output logic [OUT_WIDTH-1:0] out
);

   logic [OUT_WIDTH-1:0] last_q;
   logic [OUT_WIDTH-1:0] cand;
   logic                 found;

   // search starts just after the last grant, so that one ends up lowest
   always_comb begin
      out   = last_q;
      found = 1'b0;
      cand  = last_q;
      for (int k = 1; k <= IN_WIDTH; k++) begin
         cand = OUT_WIDTH'((int'(last_q) + k) % IN_WIDTH);
         if (!found && in[cand]) begin
            out   = cand;
            found = 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         last_q <= OUT_WIDTH'(IN_WIDTH - 1);
      end else if (advance) begin
         last_q <= out;
      end
   end

endmodule

//--- source/axi_xbar.sv
`timescale 1ns/1ps
`include "axi_fabric_settings.svh"

module axi_xbar import axi_fabric_pkg::*; #(
   parameter int NUM_SI = `AXI_NUM_SI,
   parameter int NUM_MI = `AXI_NUM_MI
) (
   input  logic                 clk,
   input  logic                 rstn,

   input  axi_aw_t [NUM_SI-1:0] s_aw,
   input  logic    [NUM_SI-1:0] s_awvalid,
   output logic    [NUM_SI-1:0] s_awready,
   input  axi_w_t  [NUM_SI-1:0] s_w,
   input  logic    [NUM_SI-1:0] s_wvalid,
   output logic    [NUM_SI-1:0] s_wready,
   output axi_b_t  [NUM_SI-1:0] s_b,
   output logic    [NUM_SI-1:0] s_bvalid,
   input  logic    [NUM_SI-1:0] s_bready,
   input  axi_ar_t [NUM_SI-1:0] s_ar,
   input  logic    [NUM_SI-1:0] s_arvalid,
   output logic    [NUM_SI-1:0] s_arready,
   output axi_r_t  [NUM_SI-1:0] s_r,
   output logic    [NUM_SI-1:0] s_rvalid,
   input  logic    [NUM_SI-1:0] s_rready,

   output axi_aw_t [NUM_MI-1:0] m_aw,
   output logic    [NUM_MI-1:0] m_awvalid,
   input  logic    [NUM_MI-1:0] m_awready,
   output axi_w_t  [NUM_MI-1:0] m_w,
   output logic    [NUM_MI-1:0] m_wvalid,
   input  logic    [NUM_MI-1:0] m_wready,
   input  axi_b_t  [NUM_MI-1:0] m_b,
   input  logic    [NUM_MI-1:0] m_bvalid,
   output logic    [NUM_MI-1:0] m_bready,
   output axi_ar_t [NUM_MI-1:0] m_ar,
   output logic    [NUM_MI-1:0] m_arvalid,
   input  logic    [NUM_MI-1:0] m_arready,
   input  axi_r_t  [NUM_MI-1:0] m_r,
   input  logic    [NUM_MI-1:0] m_rvalid,
   output logic    [NUM_MI-1:0] m_rready
);

   localparam int SI_IW    = (NUM_SI > 1) ? $clog2(NUM_SI) : 1;
   localparam int MI_IW    = (NUM_MI > 1) ? $clog2(NUM_MI) : 1;
   localparam int MI_BITS  = $clog2(NUM_MI);
   localparam int BANK_LSB = `AXI_BANK_SEL_LSB;

   typedef logic [SI_IW-1:0] si_idx_t;
   typedef logic [MI_IW-1:0] mi_idx_t;

   mi_idx_t [NUM_SI-1:0]             aw_bank;
   mi_idx_t [NUM_SI-1:0]             ar_bank;
   mi_idx_t [NUM_SI-1:0]             w_bank;
   logic    [NUM_SI-1:0]             src_busy;
   si_idx_t [NUM_MI-1:0]             aw_grant;
   si_idx_t [NUM_MI-1:0]             ar_grant;
   si_idx_t [NUM_MI-1:0]             w_src;
   logic    [NUM_MI-1:0][NUM_SI-1:0] aw_req;
   logic    [NUM_MI-1:0][NUM_SI-1:0] ar_req;
   logic    [NUM_MI-1:0]             aw_room;
   logic    [NUM_MI-1:0]             ar_room;
   logic    [NUM_MI-1:0]             w_room;
   logic    [NUM_MI-1:0]             aw_fire;
   logic    [NUM_MI-1:0]             ar_fire;
   logic    [NUM_MI-1:0]             w_fire;
   logic    [NUM_MI-1:0]             wip;
   axi_aw_t [NUM_MI-1:0]             aw_fwd;
   axi_ar_t [NUM_MI-1:0]             ar_fwd;
   si_idx_t [NUM_MI-1:0]             b_dst;
   si_idx_t [NUM_MI-1:0]             r_dst;
   mi_idx_t [NUM_SI-1:0]             b_grant;
   mi_idx_t [NUM_SI-1:0]             r_grant;
   logic    [NUM_SI-1:0][NUM_MI-1:0] b_req;
   logic    [NUM_SI-1:0][NUM_MI-1:0] r_req;
   logic    [NUM_SI-1:0]             b_room;
   logic    [NUM_SI-1:0]             r_room;
   logic    [NUM_SI-1:0]             b_fire;
   logic    [NUM_SI-1:0]             r_fire;

   function automatic mi_idx_t bank_of(axi_addr_t a);
      return mi_idx_t'((a >> BANK_LSB) & (NUM_MI - 1));
   endfunction

   // drop the select bits and close the gap so banks see a compact address
   function automatic axi_addr_t strip_bank(axi_addr_t a);
      return ((a >> (BANK_LSB + MI_BITS)) << BANK_LSB) | (a & axi_addr_t'((1 << BANK_LSB) - 1));
   endfunction

   function automatic si_idx_t src_of(axi_id_t id);
      return si_idx_t'((id >> `AXI_SRC_ID_LSB) & (NUM_SI - 1));
   endfunction

   // a source owing W beats somewhere may not open another write
   always_comb begin
      src_busy = '0;
      for (int k = 0; k < NUM_MI; k++) begin
         if (wip[k]) begin
            src_busy[w_src[k]] = 1'b1;
         end
      end
   end

   for (genvar i = 0; i < NUM_SI; i++) begin : g_src
      assign aw_bank[i] = bank_of(s_aw[i].addr);
      assign ar_bank[i] = bank_of(s_ar[i].addr);

      assign s_awready[i] = s_awvalid[i] & aw_room[aw_bank[i]] & !src_busy[i] &
                            (aw_grant[aw_bank[i]] == si_idx_t'(i));
      assign s_arready[i] = s_arvalid[i] & ar_room[ar_bank[i]] &
                            (ar_grant[ar_bank[i]] == si_idx_t'(i));
      assign s_wready[i]  = s_wvalid[i] & w_room[w_bank[i]] &
                            (w_src[w_bank[i]] == si_idx_t'(i));

      always_ff @(posedge clk) begin
         if (!rstn) begin
            w_bank[i] <= '0;
         end else if (s_awvalid[i] && s_awready[i]) begin
            w_bank[i] <= aw_bank[i];
         end
      end
   end

   for (genvar k = 0; k < NUM_MI; k++) begin : g_bank
      for (genvar i = 0; i < NUM_SI; i++) begin : g_req
         assign aw_req[k][i] = s_awvalid[i] & (aw_bank[i] == mi_idx_t'(k));
         assign ar_req[k][i] = s_arvalid[i] & (ar_bank[i] == mi_idx_t'(k));
      end

      assign aw_room[k] = (!m_awvalid[k] | m_awready[k]) & !wip[k];
      assign ar_room[k] = !m_arvalid[k] | m_arready[k];
      assign w_room[k]  = (!m_wvalid[k] | m_wready[k]) & wip[k];

      assign aw_fire[k] = s_awready[aw_grant[k]] & (aw_bank[aw_grant[k]] == mi_idx_t'(k));
      assign ar_fire[k] = s_arready[ar_grant[k]] & (ar_bank[ar_grant[k]] == mi_idx_t'(k));
      assign w_fire[k]  = s_wready[w_src[k]] & (w_bank[w_src[k]] == mi_idx_t'(k));

      always_comb begin
         aw_fwd[k]      = s_aw[aw_grant[k]];
         aw_fwd[k].addr = strip_bank(s_aw[aw_grant[k]].addr);
         ar_fwd[k]      = s_ar[ar_grant[k]];
         ar_fwd[k].addr = strip_bank(s_ar[ar_grant[k]].addr);
      end

      rr_sched #(.IN_WIDTH(NUM_SI), .OUT_WIDTH(SI_IW)) u_aw_sched (
         .clk     (clk),
         .rstn    (rstn),
         .in      (aw_req[k]),
         .advance (m_awvalid[k] & m_awready[k]),
         .out     (aw_grant[k])
      );

      rr_sched #(.IN_WIDTH(NUM_SI), .OUT_WIDTH(SI_IW)) u_ar_sched (
         .clk     (clk),
         .rstn    (rstn),
         .in      (ar_req[k]),
         .advance (m_arvalid[k] & m_arready[k]),
         .out     (ar_grant[k])
      );

      always_ff @(posedge clk) begin
         if (!rstn) begin
            m_awvalid[k] <= 1'b0;
            m_arvalid[k] <= 1'b0;
            m_wvalid[k]  <= 1'b0;
            wip[k]       <= 1'b0;
            w_src[k]     <= '0;
         end else begin
            if (aw_fire[k]) begin
               m_awvalid[k] <= 1'b1;
               w_src[k]     <= aw_grant[k];
            end else if (m_awready[k]) begin
               m_awvalid[k] <= 1'b0;
            end
            if (ar_fire[k]) begin
               m_arvalid[k] <= 1'b1;
            end else if (m_arready[k]) begin
               m_arvalid[k] <= 1'b0;
            end
            if (w_fire[k]) begin
               m_wvalid[k] <= 1'b1;
            end else if (m_wready[k]) begin
               m_wvalid[k] <= 1'b0;
            end
            // the bank stays closed to new writes until the burst's last beat passes
            if (aw_fire[k]) begin
               wip[k] <= 1'b1;
            end else if (w_fire[k] && s_w[w_src[k]].last) begin
               wip[k] <= 1'b0;
            end
         end
      end

      always_ff @(posedge clk) begin
         if (aw_fire[k]) begin
            m_aw[k] <= aw_fwd[k];
         end
         if (ar_fire[k]) begin
            m_ar[k] <= ar_fwd[k];
         end
         if (w_fire[k]) begin
            m_w[k] <= s_w[w_src[k]];
         end
      end

      // responses find their way home through the source field of the ID
      assign b_dst[k]    = src_of(m_b[k].id);
      assign r_dst[k]    = src_of(m_r[k].id);
      assign m_bready[k] = m_bvalid[k] & b_room[b_dst[k]] & (b_grant[b_dst[k]] == mi_idx_t'(k));
      assign m_rready[k] = m_rvalid[k] & r_room[r_dst[k]] & (r_grant[r_dst[k]] == mi_idx_t'(k));
   end

   for (genvar i = 0; i < NUM_SI; i++) begin : g_rsp
      for (genvar k = 0; k < NUM_MI; k++) begin : g_req
         assign b_req[i][k] = m_bvalid[k] & (b_dst[k] == si_idx_t'(i));
         assign r_req[i][k] = m_rvalid[k] & (r_dst[k] == si_idx_t'(i));
      end

      assign b_room[i] = !s_bvalid[i] | s_bready[i];
      assign r_room[i] = !s_rvalid[i] | s_rready[i];
      assign b_fire[i] = m_bready[b_grant[i]] & (b_dst[b_grant[i]] == si_idx_t'(i));
      assign r_fire[i] = m_rready[r_grant[i]] & (r_dst[r_grant[i]] == si_idx_t'(i));

      rr_sched #(.IN_WIDTH(NUM_MI), .OUT_WIDTH(MI_IW)) u_b_sched (
         .clk     (clk),
         .rstn    (rstn),
         .in      (b_req[i]),
         .advance (s_bvalid[i] & s_bready[i]),
         .out     (b_grant[i])
      );

      rr_sched #(.IN_WIDTH(NUM_MI), .OUT_WIDTH(MI_IW)) u_r_sched (
         .clk     (clk),
         .rstn    (rstn),
         .in      (r_req[i]),
         .advance (s_rvalid[i] & s_rready[i]),
         .out     (r_grant[i])
      );

      always_ff @(posedge clk) begin
         if (!rstn) begin
            s_bvalid[i] <= 1'b0;
            s_rvalid[i] <= 1'b0;
         end else begin
            if (b_fire[i]) begin
               s_bvalid[i] <= 1'b1;
            end else if (s_bready[i]) begin
               s_bvalid[i] <= 1'b0;
            end
            if (r_fire[i]) begin
               s_rvalid[i] <= 1'b1;
            end else if (s_rready[i]) begin
               s_rvalid[i] <= 1'b0;
            end
         end
      end

      always_ff @(posedge clk) begin
         if (b_fire[i]) begin
            s_b[i] <= m_b[b_grant[i]];
         end
         if (r_fire[i]) begin
            s_r[i] <= m_r[r_grant[i]];
         end
      end
   end

endmodule

//--- source/axi_mem_bank.sv
`timescale 1ns/1ps
`include "axi_fabric_settings.svh"

module axi_mem_bank import axi_fabric_pkg::*; #(
   parameter int WORDS = `AXI_BANK_WORDS
) (
   input  logic    clk,
   input  logic    rstn,
   input  axi_aw_t aw,
   input  logic    awvalid,
   output logic    awready,
   input  axi_w_t  w,
   input  logic    wvalid,
   output logic    wready,
   output axi_b_t  b,
   output logic    bvalid,
   input  logic    bready,
   input  axi_ar_t ar,
   input  logic    arvalid,
   output logic    arready,
   output axi_r_t  r,
   output logic    rvalid,
   input  logic    rready
);

   localparam int IW = (WORDS > 1) ? $clog2(WORDS) : 1;

   axi_data_t   mem [WORDS];
   bank_state_e state_q;
   logic        prefer_rd_q;
   axi_addr_t   idx_q;
   axi_len_t    cnt_q;
   axi_id_t     bid_q;
   axi_resp_e   bresp_q;
   axi_r_t      r_q;
   axi_addr_t   rd_idx;
   logic        aw_fire;
   logic        w_fire;
   logic        ar_fire;
   logic        r_fire;
   logic        rd_step;
   logic        wr_in;
   logic        rd_in;

   // when both wait in IDLE the side that went last yields
   assign awready = (state_q == IDLE) & (!arvalid | !prefer_rd_q);
   assign arready = (state_q == IDLE) & (!awvalid | prefer_rd_q);
   assign wready  = (state_q == WRITE);
   assign bvalid  = (state_q == WRESP);
   assign rvalid  = (state_q == READ);
   assign b       = '{id: bid_q, resp: bresp_q};
   assign r       = r_q;

   assign aw_fire = awready & awvalid;
   assign w_fire  = wready & wvalid;
   assign ar_fire = arready & arvalid;
   assign r_fire  = rvalid & rready;

   // the next read beat is fetched at acceptance and after each transfer
   assign rd_step = ar_fire | (r_fire & !r_q.last);
   assign rd_idx  = ar_fire ? (ar.addr >> 2) : idx_q;
   assign wr_in   = idx_q < WORDS;
   assign rd_in   = rd_idx < WORDS;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state_q     <= IDLE;
         prefer_rd_q <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (aw_fire) begin
                  state_q     <= WRITE;
                  prefer_rd_q <= 1'b1;
               end else if (ar_fire) begin
                  state_q     <= READ;
                  prefer_rd_q <= 1'b0;
               end
            end
            WRITE: begin
               if (w_fire && w.last) begin
                  state_q <= WRESP;
               end
            end
            WRESP: begin
               if (bready) begin
                  state_q <= IDLE;
               end
            end
            READ: begin
               if (r_fire && r_q.last) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (w_fire && wr_in) begin
         mem[idx_q[IW-1:0]] <= w.data;
      end
   end

   always_ff @(posedge clk) begin
      if (aw_fire) begin
         idx_q   <= aw.addr >> 2;
         bid_q   <= aw.id;
         bresp_q <= OKAY;
      end
      if (w_fire) begin
         idx_q <= idx_q + 1'b1;
         // one stray beat spoils the whole burst response
         if (!wr_in) begin
            bresp_q <= SLVERR;
         end
      end
      if (ar_fire) begin
         r_q.id   <= ar.id;
         r_q.last <= (ar.len == '0);
         cnt_q    <= ar.len;
      end else if (rd_step) begin
         r_q.last <= (cnt_q == 8'd1);
         cnt_q    <= cnt_q - 1'b1;
      end
      if (rd_step) begin
         idx_q <= rd_idx + 1'b1;
         if (rd_in) begin
            r_q.data <= mem[rd_idx[IW-1:0]];
            r_q.resp <= OKAY;
         end else begin
            r_q.data <= '0;
            r_q.resp <= SLVERR;
         end
      end
   end

endmodule

//--- source/axi_fabric_top.sv
`timescale 1ns/1ps
`include "axi_fabric_settings.svh"

module axi_fabric_top import axi_fabric_pkg::*; (
   input  logic                      clk,
   input  logic                      rstn,
   input  axi_aw_t [`AXI_NUM_SI-1:0] s_aw,
   input  logic    [`AXI_NUM_SI-1:0] s_awvalid,
   output logic    [`AXI_NUM_SI-1:0] s_awready,
   input  axi_w_t  [`AXI_NUM_SI-1:0] s_w,
   input  logic    [`AXI_NUM_SI-1:0] s_wvalid,
   output logic    [`AXI_NUM_SI-1:0] s_wready,
   output axi_b_t  [`AXI_NUM_SI-1:0] s_b,
   output logic    [`AXI_NUM_SI-1:0] s_bvalid,
   input  logic    [`AXI_NUM_SI-1:0] s_bready,
   input  axi_ar_t [`AXI_NUM_SI-1:0] s_ar,
   input  logic    [`AXI_NUM_SI-1:0] s_arvalid,
   output logic    [`AXI_NUM_SI-1:0] s_arready,
   output axi_r_t  [`AXI_NUM_SI-1:0] s_r,
   output logic    [`AXI_NUM_SI-1:0] s_rvalid,
   input  logic    [`AXI_NUM_SI-1:0] s_rready
);

   axi_aw_t [`AXI_NUM_MI-1:0] m_aw;
   logic    [`AXI_NUM_MI-1:0] m_awvalid;
   logic    [`AXI_NUM_MI-1:0] m_awready;
   axi_w_t  [`AXI_NUM_MI-1:0] m_w;
   logic    [`AXI_NUM_MI-1:0] m_wvalid;
   logic    [`AXI_NUM_MI-1:0] m_wready;
   axi_b_t  [`AXI_NUM_MI-1:0] m_b;
   logic    [`AXI_NUM_MI-1:0] m_bvalid;
   logic    [`AXI_NUM_MI-1:0] m_bready;
   axi_ar_t [`AXI_NUM_MI-1:0] m_ar;
   logic    [`AXI_NUM_MI-1:0] m_arvalid;
   logic    [`AXI_NUM_MI-1:0] m_arready;
   axi_r_t  [`AXI_NUM_MI-1:0] m_r;
   logic    [`AXI_NUM_MI-1:0] m_rvalid;
   logic    [`AXI_NUM_MI-1:0] m_rready;

   axi_xbar #(.NUM_SI(`AXI_NUM_SI), .NUM_MI(`AXI_NUM_MI)) u_xbar (.*);

   for (genvar k = 0; k < `AXI_NUM_MI; k++) begin : g_bank
      axi_mem_bank #(.WORDS(`AXI_BANK_WORDS)) u_bank (
         .clk     (clk),
         .rstn    (rstn),
         .aw      (m_aw[k]),
         .awvalid (m_awvalid[k]),
         .awready (m_awready[k]),
         .w       (m_w[k]),
         .wvalid  (m_wvalid[k]),
         .wready  (m_wready[k]),
         .b       (m_b[k]),
         .bvalid  (m_bvalid[k]),
         .bready  (m_bready[k]),
         .ar      (m_ar[k]),
         .arvalid (m_arvalid[k]),
         .arready (m_arready[k]),
         .r       (m_r[k]),
         .rvalid  (m_rvalid[k]),
         .rready  (m_rready[k])
      );
   end

endmodule

//--- verification/axi_fabric_checker.sv
`timescale 1ns/1ps
`include "axi_fabric_settings.svh"

module axi_fabric_checker import axi_fabric_pkg::*; (
   input logic                      clk,
   input logic                      rstn,
   input axi_aw_t [`AXI_NUM_SI-1:0] s_aw,
   input logic    [`AXI_NUM_SI-1:0] s_awvalid,
   input logic    [`AXI_NUM_SI-1:0] s_awready,
   input axi_w_t  [`AXI_NUM_SI-1:0] s_w,
   input logic    [`AXI_NUM_SI-1:0] s_wvalid,
   input logic    [`AXI_NUM_SI-1:0] s_wready,
   input axi_b_t  [`AXI_NUM_SI-1:0] s_b,
   input logic    [`AXI_NUM_SI-1:0] s_bvalid,
   input logic    [`AXI_NUM_SI-1:0] s_bready,
   input axi_ar_t [`AXI_NUM_SI-1:0] s_ar,
   input logic    [`AXI_NUM_SI-1:0] s_arvalid,
   input logic    [`AXI_NUM_SI-1:0] s_arready,
   input axi_r_t  [`AXI_NUM_SI-1:0] s_r,
   input logic    [`AXI_NUM_SI-1:0] s_rvalid,
   input logic    [`AXI_NUM_SI-1:0] s_rready
);

   // reference memory keyed by global word address
   axi_data_t ref_mem [axi_addr_t];
   axi_addr_t wr_open [axi_id_t];
   axi_addr_t rd_open [axi_id_t];
   int        rd_len [axi_id_t];
   int        rd_beat [axi_id_t];
   axi_addr_t w_addr [`AXI_NUM_SI];
   int        w_beat [`AXI_NUM_SI];
   int        errors = 0;
   int        checks = 0;
   int        err_mark = 0;
   int        chk_mark = 0;
   int        n_aw = 0;
   int        n_b = 0;
   int        n_rd_exp = 0;
   int        n_r = 0;

   function automatic void expect_word(input axi_addr_t a, output axi_data_t d,
                                       output axi_resp_e r);
      axi_addr_t loc;
      // word index inside the bank once the two select bits are taken out
      loc = {2'b00, a[`AXI_ADDR_W-1:`AXI_BANK_SEL_LSB+2], a[`AXI_BANK_SEL_LSB-1:0]} >> 2;
      if (loc >= `AXI_BANK_WORDS) begin
         d = '0;
         r = SLVERR;
      end else begin
         d = ref_mem.exists(a >> 2) ? ref_mem[a >> 2] : '0;
         r = OKAY;
      end
   endfunction

   function automatic int src_of_id(input axi_id_t id);
      return int'(id[`AXI_ID_W-1:`AXI_SRC_ID_LSB]);
   endfunction

   task automatic check_b(input int i);
      axi_b_t    bb;
      axi_data_t d;
      axi_resp_e r;
      bb = s_b[i];
      n_b++;
      if (src_of_id(bb.id) != i) begin
         $display("source %0d got a write response with id %h meant for source %0d",
                  i, bb.id, src_of_id(bb.id));
         errors++;
      end
      if (!wr_open.exists(bb.id)) begin
         $display("source %0d got a write response with id %h and no open write", i, bb.id);
         errors++;
      end else begin
         expect_word(wr_open[bb.id], d, r);
         checks++;
         if (bb.resp !== r) begin
            $display("FAILED at %0t: source %0d B id %h resp %0d, expected %0d",
                     $time, i, bb.id, bb.resp, r);
            errors++;
         end
         wr_open.delete(bb.id);
      end
   endtask

   task automatic check_r(input int i);
      axi_r_t    rb;
      axi_data_t d;
      axi_resp_e r;
      int        beat;
      logic      last_exp;
      rb = s_r[i];
      n_r++;
      if (src_of_id(rb.id) != i) begin
         $display("source %0d got read data with id %h meant for source %0d",
                  i, rb.id, src_of_id(rb.id));
         errors++;
      end
      if (!rd_open.exists(rb.id)) begin
         $display("source %0d got read data with id %h and no open read", i, rb.id);
         errors++;
      end else begin
         beat     = rd_beat[rb.id];
         last_exp = (beat == rd_len[rb.id] - 1);
         expect_word(axi_addr_t'(rd_open[rb.id] + 4 * beat), d, r);
         checks++;
         if (rb.data !== d || rb.resp !== r || rb.last !== last_exp) begin
            $display("FAILED at %0t: src %0d R id %h beat %0d got %h %0d %b, expected %h %0d %b",
                     $time, i, rb.id, beat, rb.data, rb.resp, rb.last, d, r, last_exp);
            errors++;
         end
         if (last_exp) begin
            rd_open.delete(rb.id);
            rd_len.delete(rb.id);
            rd_beat.delete(rb.id);
         end else begin
            rd_beat[rb.id] = beat + 1;
         end
      end
   endtask

   always @(posedge clk) begin
      if (rstn) begin
         for (int i = 0; i < `AXI_NUM_SI; i++) begin
            if (s_awvalid[i] && s_awready[i]) begin
               wr_open[s_aw[i].id] = s_aw[i].addr;
               w_addr[i] = s_aw[i].addr;
               w_beat[i] = 0;
               n_aw++;
            end
            // W beats of a source always belong to its latest accepted AW
            if (s_wvalid[i] && s_wready[i]) begin
               ref_mem[axi_addr_t'((w_addr[i] >> 2) + w_beat[i])] = s_w[i].data;
               w_beat[i]++;
            end
            if (s_arvalid[i] && s_arready[i]) begin
               rd_open[s_ar[i].id] = s_ar[i].addr;
               rd_len[s_ar[i].id]  = int'(s_ar[i].len) + 1;
               rd_beat[s_ar[i].id] = 0;
               n_rd_exp += int'(s_ar[i].len) + 1;
            end
            if (s_bvalid[i] && s_bready[i]) begin
               check_b(i);
            end
            if (s_rvalid[i] && s_rready[i]) begin
               check_r(i);
            end
         end
      end
   end

   task automatic end_test(input string name);
      $display("test %s: %s (%0d checks, %0d errors)", name,
               (errors == err_mark) ? "pass" : "fail", checks - chk_mark, errors - err_mark);
      err_mark = errors;
      chk_mark = checks;
   endtask

   task automatic close_run(output int total);
      if (n_b != n_aw || n_r != n_rd_exp) begin
         $display("response count is wrong, %0d B for %0d writes, %0d R for %0d read beats",
                  n_b, n_aw, n_r, n_rd_exp);
         errors++;
      end
      if (wr_open.num() != 0 || rd_open.num() != 0) begin
         $display("%0d writes and %0d reads never got their full response",
                  wr_open.num(), rd_open.num());
         errors++;
      end
      $display("checks %0d, errors %0d, B beats %0d, R beats %0d", checks, errors, n_b, n_r);
      total = errors;
   endtask

endmodule

//--- verification/axi_fabric_tb.sv
`timescale 1ns/1ps
`include "axi_fabric_settings.svh"

module axi_fabric_tb import axi_fabric_pkg::*; ();

   // bursts over all five tests, and the longest burst
   localparam int NUM_BURSTS = 300;
   localparam int MAX_BEATS  = 16;

   logic                      clk;
   logic                      rstn;
   axi_aw_t [`AXI_NUM_SI-1:0] s_aw;
   logic    [`AXI_NUM_SI-1:0] s_awvalid;
   logic    [`AXI_NUM_SI-1:0] s_awready;
   axi_w_t  [`AXI_NUM_SI-1:0] s_w;
   logic    [`AXI_NUM_SI-1:0] s_wvalid;
   logic    [`AXI_NUM_SI-1:0] s_wready;
   axi_b_t  [`AXI_NUM_SI-1:0] s_b;
   logic    [`AXI_NUM_SI-1:0] s_bvalid;
   logic    [`AXI_NUM_SI-1:0] s_bready;
   axi_ar_t [`AXI_NUM_SI-1:0] s_ar;
   logic    [`AXI_NUM_SI-1:0] s_arvalid;
   logic    [`AXI_NUM_SI-1:0] s_arready;
   axi_r_t  [`AXI_NUM_SI-1:0] s_r;
   logic    [`AXI_NUM_SI-1:0] s_rvalid;
   logic    [`AXI_NUM_SI-1:0] s_rready;
   logic                      bp_on;
   int                        tag_cnt [`AXI_NUM_SI];
   int                        total;

   axi_fabric_top u_dut (.*);

   axi_fabric_checker u_chk (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // line above the bank select, bank, then word inside the 64-byte line
   function automatic axi_addr_t addr_of(input int bank, input int line, input int word);
      return axi_addr_t'((line << (`AXI_BANK_SEL_LSB + 2)) | (bank << `AXI_BANK_SEL_LSB) |
                         (word << 2));
   endfunction

   task automatic write_burst(input int s, input axi_addr_t addr, input int beats);
      axi_id_t id;
      id = axi_id_t'((s << `AXI_SRC_ID_LSB) | (tag_cnt[s] % (1 << `AXI_SRC_ID_LSB)));
      tag_cnt[s]++;
      @(negedge clk);
      s_aw[s]      = '{id: id, addr: addr, len: axi_len_t'(beats - 1), size: 3'd2};
      s_awvalid[s] = 1'b1;
      do @(posedge clk); while (!s_awready[s]);
      for (int n = 0; n < beats; n++) begin
         @(negedge clk);
         s_awvalid[s] = 1'b0;
         s_w[s]       = '{id: id, data: $urandom, last: (n == beats - 1)};
         s_wvalid[s]  = 1'b1;
         do @(posedge clk); while (!s_wready[s]);
      end
      @(negedge clk);
      s_wvalid[s] = 1'b0;
      do @(posedge clk); while (!(s_bvalid[s] && s_bready[s]));
   endtask

   task automatic read_burst(input int s, input axi_addr_t addr, input int beats);
      axi_id_t id;
      int      got;
      id = axi_id_t'((s << `AXI_SRC_ID_LSB) | (tag_cnt[s] % (1 << `AXI_SRC_ID_LSB)));
      tag_cnt[s]++;
      got = 0;
      @(negedge clk);
      s_ar[s]      = '{id: id, addr: addr, len: axi_len_t'(beats - 1), size: 3'd2};
      s_arvalid[s] = 1'b1;
      do @(posedge clk); while (!s_arready[s]);
      @(negedge clk);
      s_arvalid[s] = 1'b0;
      while (got < beats) begin
         @(posedge clk);
         if (s_rvalid[s] && s_rready[s]) begin
            got++;
         end
      end
   endtask

   // each source keeps to its own lines so parallel sources never share a word
   task automatic source_test(input int t, input int s);
      int beats;
      int start;
      int bank;
      int line;
      case (t)
         1: begin
            for (int b = 0; b < `AXI_NUM_MI; b++) begin
               write_burst(s, addr_of(b, s, b), 1);
               read_burst(s, addr_of(b, s, b), 1);
            end
         end
         2: begin
            for (int b = 0; b < `AXI_NUM_MI; b++) begin
               for (int n = 1; n <= 4; n++) begin
                  beats = 4 * s + n;
                  start = $urandom % (17 - beats);
                  write_burst(s, addr_of(b, 4 + s, start), beats);
                  read_burst(s, addr_of(b, 4 + s, start), beats);
               end
            end
         end
         3: begin
            for (int rep = 0; rep < 4; rep++) begin
               write_burst(s, addr_of(2, 8 + s, 4 * rep), 4);
               read_burst(s, addr_of(2, 8 + s, 4 * rep), 4);
            end
         end
         4: begin
            // the in-range read covers the words a stray out-of-range write would wrap onto
            write_burst(s, addr_of(s, 16 + 17 * s, 2), 2);
            read_burst(s, addr_of(s, 16 + 17 * s, 2), 2);
            read_burst(s, addr_of(s, s, 2), 2);
         end
         default: begin
            // fill the lines first so no random read meets an unwritten word
            for (int b = 0; b < `AXI_NUM_MI; b++) begin
               write_burst(s, addr_of(b, 12 + s, 0), MAX_BEATS);
            end
            for (int n = 0; n < 20; n++) begin
               bank  = $urandom % `AXI_NUM_MI;
               line  = (($urandom % 8) == 0) ? 16 + s : 12 + s;
               beats = 1 + $urandom % MAX_BEATS;
               start = $urandom % (17 - beats);
               if ($urandom % 2) begin
                  write_burst(s, addr_of(bank, line, start), beats);
               end else begin
                  read_burst(s, addr_of(bank, line, start), beats);
               end
            end
         end
      endcase
   endtask

   task automatic run_all(input int t);
      fork
         source_test(t, 0);
         source_test(t, 1);
         source_test(t, 2);
         source_test(t, 3);
      join
      // let the checker take the last response before the test is closed
      @(negedge clk);
   endtask

   initial begin
      forever begin
         @(negedge clk);
         for (int i = 0; i < `AXI_NUM_SI; i++) begin
            s_bready[i] = bp_on ? (($urandom % 4) != 0) : 1'b1;
            s_rready[i] = bp_on ? (($urandom % 3) != 0) : 1'b1;
         end
      end
   end

   initial begin
      repeat (NUM_BURSTS * (MAX_BEATS + 20) * 4) @(posedge clk);
      $display("timeout: the tests did not finish within %0d cycles",
               NUM_BURSTS * (MAX_BEATS + 20) * 4);
      $display("Done: errors found");
      $finish;
   end

   initial begin
      rstn      = 1'b0;
      s_aw      = '0;
      s_awvalid = '0;
      s_w       = '0;
      s_wvalid  = '0;
      s_bready  = '1;
      s_ar      = '0;
      s_arvalid = '0;
      s_rready  = '1;
      bp_on     = 1'b0;
      for (int i = 0; i < `AXI_NUM_SI; i++) begin
         tag_cnt[i] = 0;
      end
      void'($urandom(32'hd2c9));
      repeat (5) @(posedge clk);
      @(negedge clk);
      rstn = 1'b1;
      run_all(1);
      u_chk.end_test("1 single beat per source and bank");
      run_all(2);
      u_chk.end_test("2 bursts of 1 to 16 beats");
      run_all(3);
      u_chk.end_test("3 all sources on one bank");
      run_all(4);
      u_chk.end_test("4 out of range access");
      bp_on = 1'b1;
      run_all(5);
      bp_on = 1'b0;
      u_chk.end_test("5 mixed traffic with back-pressure");
      repeat (4) @(posedge clk);
      u_chk.close_run(total);
      if (total == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- axi_fabric.f
+incdir+include
source/axi_fabric_pkg.sv
source/rr_sched.sv
source/axi_xbar.sv
source/axi_mem_bank.sv
source/axi_fabric_top.sv
verification/axi_fabric_checker.sv
verification/axi_fabric_tb.sv
